/* project.f */
+incdir+rtl
rtl/tlu_pkg.sv
rtl/tlu_conf_regs.sv
rtl/trigger_input.sv
rtl/tlu_trigger_fsm.sv
rtl/handshake_timer.sv
rtl/trigger_counter.sv
rtl/trigger_fifo.sv
rtl/tlu_controller.sv
testbench/tb_tlu_controller.sv

/* testbench/tb_tlu_controller.sv */
`timescale 1ns/1ps
`include "tlu_macros.svh"

module tb_tlu_controller;

    // about 25 triggers of under 40 cycles each plus bus traffic, with wide margin
    localparam int MAX_CYCLES = 20000;

    logic                BUS_CLK;
    logic                RST;
    tlu_pkg::bus_addr_t  bus_add;
    tlu_pkg::bus_byte_t  bus_data_in;
    logic                bus_rd;
    logic                bus_wr;
    tlu_pkg::bus_byte_t  bus_data_out;
    tlu_pkg::trig_mask_t trigger;
    tlu_pkg::trig_mask_t trigger_veto;
    logic                tlu_trigger;
    logic                trigger_enable;
    logic                trigger_acknowledge;
    logic                trigger_accepted_flag;
    logic                tlu_busy;
    logic                fifo_read;
    logic                fifo_empty;
    tlu_pkg::trig_word_t fifo_data;

    tlu_pkg::trig_mask_t trig_idle;       // trigger value with all lines inactive
    logic [31:0]         lfsr;
    int                  cycles = 0;
    string               test_name;
    tlu_pkg::trig_word_t exp_count;
    tlu_pkg::trig_word_t exp_words [$];   // expected FIFO contents
    int                  exp_lost;
    int                  exp_timeout_err;

    tlu_controller u_tlu_controller (
        .BUS_CLK               (BUS_CLK),
        .RST                   (RST),
        .bus_add               (bus_add),
        .bus_data_in           (bus_data_in),
        .bus_rd                (bus_rd),
        .bus_wr                (bus_wr),
        .bus_data_out          (bus_data_out),
        .trigger               (trigger),
        .trigger_veto          (trigger_veto),
        .tlu_trigger           (tlu_trigger),
        .trigger_enable        (trigger_enable),
        .trigger_acknowledge   (trigger_acknowledge),
        .trigger_accepted_flag (trigger_accepted_flag),
        .tlu_busy              (tlu_busy),
        .fifo_read             (fifo_read),
        .fifo_empty            (fifo_empty),
        .fifo_data             (fifo_data)
    );

    initial
    begin
        BUS_CLK = 1'b0;
        forever #5 BUS_CLK = ~BUS_CLK;
    end

    always @(posedge BUS_CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic tick(input int n);
        repeat (n)
        begin
            @(posedge BUS_CLK);
            #1;   // inputs change just after the edge
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("ERROR %s %s: expected %0h actual %0h", test_name, what, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic bus_write(input tlu_pkg::bus_addr_t addr, input tlu_pkg::bus_byte_t data);
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        tick(1);
        bus_wr      = 1'b0;
    endtask

    task automatic bus_read(input tlu_pkg::bus_addr_t addr, output tlu_pkg::bus_byte_t data);
        bus_add = addr;
        bus_rd  = 1'b1;
        tick(1);
        bus_rd  = 1'b0;
        data    = bus_data_out;   // registered one cycle after the strobe
    endtask

    task automatic check_reg(input tlu_pkg::bus_addr_t addr, input tlu_pkg::bus_byte_t expected,
                             input string what);
        tlu_pkg::bus_byte_t data;
        bus_read(addr, data);
        check_value(what, expected, data);
    endtask

    task automatic check_count();
        tlu_pkg::trig_word_t cnt;
        tlu_pkg::bus_byte_t  data;
        int                  b;
        for (b = 0; b < 4; b++)
        begin
            bus_read(`ADDR_COUNTER0 + b, data);   // byte 0 latches the upper bytes
            cnt[8*b +: 8] = data;
        end
        check_value("trigger counter", exp_count, cnt);
    endtask

    task automatic model_accept();
        if (exp_words.size() < `FIFO_DEPTH)
            exp_words.push_back(exp_count);   // number before the increment
        else if (exp_lost < 255)
            exp_lost++;
        exp_count++;
    endtask

    task automatic fire_trigger(input int line, output int accepts);
        int c;
        accepts = 0;
        trigger = trig_idle ^ (8'h01 << line);
        for (c = 0; c < 20; c++)
        begin
            if (c == 8)
                trigger = trig_idle;   // pulse held 8 cycles
            tick(1);
            if (trigger_accepted_flag)
                accepts++;
        end
    endtask

    task automatic send_ack();
        tick(rand_bits(3));
        trigger_acknowledge = 1'b1;
        tick(1);
        trigger_acknowledge = 1'b0;
    endtask

    task automatic std_trigger(input int line, input int expected);
        int accepts;
        fire_trigger(line, accepts);
        check_value("accept count", expected, accepts);
        if (expected != 0)
        begin
            model_accept();
            send_ack();
        end
    endtask

    task automatic tlu_start();
        int c;
        int accepts;
        accepts     = 0;
        tlu_trigger = 1'b1;
        for (c = 0; c < 20; c++)
        begin
            tick(1);
            if (trigger_accepted_flag)
            begin
                accepts++;
                check_value("busy with accept", 1, tlu_busy);
            end
        end
        check_value("handshake accept count", 1, accepts);
        model_accept();
    endtask

    task automatic wait_busy_low();
        int c;
        c = 0;
        while (tlu_busy && c < 20)
        begin
            tick(1);
            c++;
        end
        check_value("busy falls", 0, tlu_busy);
    endtask

    task automatic pop_word();
        check_value("fifo_empty before pop", 0, fifo_empty);
        check_value("fifo word", exp_words[0], fifo_data);
        fifo_read = 1'b1;
        tick(1);
        fifo_read = 1'b0;
        void'(exp_words.pop_front());
    endtask

    task automatic soft_reset();
        bus_write(`ADDR_SOFT_RST_VERSION, 8'h00);
        tick(3);
        trig_idle       = '0;   // select is zero again, lines are don't care
        trigger         = '0;
        exp_count       = '0;
        exp_lost        = 0;
        exp_timeout_err = 0;
        exp_words.delete();
    endtask

    initial
    begin
        tlu_pkg::bus_addr_t  addrs [9];
        tlu_pkg::bus_byte_t  vals [9];
        tlu_pkg::trig_mask_t inv;
        tlu_pkg::trig_mask_t sel;
        tlu_pkg::trig_word_t preset;
        tlu_pkg::trig_word_t max_val;
        int                  sel_line;
        int                  off_line;
        int                  line;
        int                  n;
        int                  b;
        int                  accepts;

        lfsr                = 32'h83e3;
        RST                 = 1'b1;
        bus_add             = '0;
        bus_data_in         = '0;
        bus_rd              = 1'b0;
        bus_wr              = 1'b0;
        trigger             = '0;
        trigger_veto        = '0;
        tlu_trigger         = 1'b0;
        trigger_enable      = 1'b0;
        trigger_acknowledge = 1'b0;
        fifo_read           = 1'b0;
        trig_idle           = '0;
        exp_count           = '0;
        exp_lost            = 0;
        exp_timeout_err     = 0;
        tick(2);
        RST = 1'b0;
        tick(2);

        test_name = "reset_defaults";
        check_value("fifo_empty after reset", 1, fifo_empty);
        check_value("busy after reset", 0, tlu_busy);
        check_reg(`ADDR_SOFT_RST_VERSION, `TLU_VERSION, "version");
        check_reg(`ADDR_VETO_SELECT, `DEF_VETO_SELECT, "veto select default");
        check_reg(`ADDR_LOW_TIMEOUT, `DEF_LOW_TIMEOUT, "low timeout default");
        check_reg(`ADDR_LOST_CNT, 8'h00, "lost count");
        check_count();
        for (n = 0; n < 9; n++)
        begin
            addrs[n] = (n == 0) ? `ADDR_CONF :
                       (n == 1) ? `ADDR_LOW_TIMEOUT : `ADDR_TRIG_SELECT + n - 2;
            vals[n]  = rand_bits(8);
        end
        vals[0][3] = 1'b0;   // enable stays off
        for (n = 0; n < 9; n++)
            bus_write(addrs[n], vals[n]);
        for (n = 0; n < 9; n++)
            check_reg(addrs[n], vals[n], "register readback");
        soft_reset();

        test_name = "standard";
        sel_line  = rand_bits(3);
        off_line  = (sel_line + 1) % 8;
        inv       = rand_bits(8);
        sel       = rand_bits(8);
        sel[sel_line] = 1'b1;
        sel[off_line] = 1'b0;
        trig_idle = inv;
        trigger   = inv;
        bus_write(`ADDR_TRIG_INVERT, inv);
        bus_write(`ADDR_TRIG_SELECT, sel);
        bus_write(`ADDR_CONF, 8'h08);
        tick(20);
        for (n = 0; n < 4; n++)
        begin
            line = rand_bits(3);
            while (!sel[line])
                line = rand_bits(3);
            std_trigger(line, 1);
            pop_word();
            check_count();   // word plus one
        end
        std_trigger(off_line, 0);
        check_value("fifo_empty unselected line", 1, fifo_empty);
        check_count();

        test_name    = "veto";
        trigger_veto = 8'h01 << rand_bits(3);
        tick(20);
        std_trigger(sel_line, 0);
        check_value("fifo_empty under veto", 1, fifo_empty);
        check_count();
        trigger_veto = '0;
        tick(20);

        test_name = "preset_limit";
        preset    = rand_bits(31);   // no wrap at preset plus 3
        max_val   = preset + 32'd3;
        for (b = 0; b < 4; b++)
            bus_write(`ADDR_COUNTER0 + b, preset[8*b +: 8]);
        exp_count = preset;
        for (b = 0; b < 4; b++)
            bus_write(`ADDR_MAX0 + b, max_val[8*b +: 8]);
        for (n = 0; n < 5; n++)
            std_trigger(sel_line, (exp_count < max_val) ? 1 : 0);
        for (n = 0; n < 3; n++)
        begin
            check_value("consecutive number", preset + n, fifo_data);
            pop_word();
        end
        check_value("fifo_empty after limit", 1, fifo_empty);
        check_count();
        for (b = 0; b < 4; b++)
            bus_write(`ADDR_MAX0 + b, 8'h00);

        test_name = "handshake";
        bus_write(`ADDR_LOW_TIMEOUT, 8'd32 + rand_bits(5));
        bus_write(`ADDR_CONF, 8'h09);
        tick(5);
        tlu_start();
        tick(rand_bits(3));
        check_value("busy while trigger high", 1, tlu_busy);
        tlu_trigger = 1'b0;
        tick(20);
        check_value("busy until ack", 1, tlu_busy);
        send_ack();
        wait_busy_low();
        check_reg(`ADDR_TIMEOUT_ERR, exp_timeout_err, "no timeout error");

        test_name = "handshake_timeout";
        bus_write(`ADDR_LOW_TIMEOUT, 8'd4 + rand_bits(2));
        tlu_start();
        wait_busy_low();   // trigger still high, no ack
        exp_timeout_err++;
        check_reg(`ADDR_TIMEOUT_ERR, exp_timeout_err, "timeout errors");
        tlu_trigger = 1'b0;
        accepts     = 0;
        for (n = 0; n < 20; n++)
        begin
            tick(1);
            if (trigger_accepted_flag)
                accepts++;
        end
        check_value("busy after trigger low", 0, tlu_busy);
        check_value("no accept on falling edge", 0, accepts);
        pop_word();
        pop_word();
        check_count();
        bus_write(`ADDR_CONF, 8'h08);
        tick(20);

        test_name = "overflow";
        for (n = 0; n < 10; n++)
            std_trigger(sel_line, 1);
        check_reg(`ADDR_LOST_CNT, 8'd2, "lost count");
        check_reg(`ADDR_LOST_CNT, exp_lost, "lost count model");
        for (n = 0; n < 8; n++)
            pop_word();
        check_value("fifo_empty after drain", 1, fifo_empty);
        std_trigger(sel_line, 1);
        std_trigger(sel_line, 1);
        check_value("fifo_empty before soft reset", 0, fifo_empty);
        soft_reset();
        check_value("fifo_empty after soft reset", 1, fifo_empty);
        check_count();
        check_reg(`ADDR_LOST_CNT, 8'h00, "lost count cleared");
        check_reg(`ADDR_TIMEOUT_ERR, 8'h00, "timeout errors cleared");

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* rtl/tlu_controller.sv */
`timescale 1ns/1ps

module tlu_controller
(
    input  logic                BUS_CLK,
    input  logic                RST,
    input  tlu_pkg::bus_addr_t  bus_add,
    input  tlu_pkg::bus_byte_t  bus_data_in,
    input  logic                bus_rd,
    input  logic                bus_wr,
    output tlu_pkg::bus_byte_t  bus_data_out,
    input  tlu_pkg::trig_mask_t trigger,
    input  tlu_pkg::trig_mask_t trigger_veto,
    input  logic                tlu_trigger,
    input  logic                trigger_enable,
    input  logic                trigger_acknowledge,
    output logic                trigger_accepted_flag,
    output logic                tlu_busy,
    input  logic                fifo_read,
    output logic                fifo_empty,
    output tlu_pkg::trig_word_t fifo_data
);

    logic                      core_rst;
    tlu_pkg::tlu_conf_t        conf;
    wire tlu_pkg::tlu_status_t status;    // fields driven by three blocks
    logic                      counter_set;
    tlu_pkg::trig_word_t       counter_set_value;
    logic                      trig_level;
    logic                      trig_flag;
    logic                      veto_active;
    logic                      limit_reached;
    logic                      timer_run;
    logic                      timeout;

    tlu_conf_regs u_conf_regs (
        .BUS_CLK           (BUS_CLK),
        .RST               (RST),
        .bus_add           (bus_add),
        .bus_data_in       (bus_data_in),
        .bus_rd            (bus_rd),
        .bus_wr            (bus_wr),
        .status            (status),
        .bus_data_out      (bus_data_out),
        .core_rst          (core_rst),
        .conf              (conf),
        .counter_set       (counter_set),
        .counter_set_value (counter_set_value)
    );

    trigger_input u_trigger_input (
        .BUS_CLK      (BUS_CLK),
        .core_rst     (core_rst),
        .conf         (conf),
        .trigger      (trigger),
        .trigger_veto (trigger_veto),
        .tlu_trigger  (tlu_trigger),
        .trig_level   (trig_level),
        .trig_flag    (trig_flag),
        .veto_active  (veto_active)
    );

    tlu_trigger_fsm u_trigger_fsm (
        .BUS_CLK             (BUS_CLK),
        .core_rst            (core_rst),
        .conf                (conf),
        .trigger_enable      (trigger_enable),
        .trigger_acknowledge (trigger_acknowledge),
        .trig_level          (trig_level),
        .trig_flag           (trig_flag),
        .veto_active         (veto_active),
        .limit_reached       (limit_reached),
        .timeout             (timeout),
        .accept              (trigger_accepted_flag),
        .busy                (tlu_busy),
        .timer_run           (timer_run)
    );

    handshake_timer u_handshake_timer (
        .BUS_CLK         (BUS_CLK),
        .core_rst        (core_rst),
        .conf            (conf),
        .timer_run       (timer_run),
        .timeout         (timeout),
        .timeout_err_cnt (status.timeout_err_cnt)
    );

    trigger_counter u_trigger_counter (
        .BUS_CLK           (BUS_CLK),
        .core_rst          (core_rst),
        .conf              (conf),
        .counter_set       (counter_set),
        .counter_set_value (counter_set_value),
        .accept            (trigger_accepted_flag),
        .trig_count        (status.trig_count),
        .limit_reached     (limit_reached)
    );

    // stores the count before this accept's increment
    trigger_fifo u_trigger_fifo (
        .BUS_CLK    (BUS_CLK),
        .core_rst   (core_rst),
        .write      (trigger_accepted_flag),
        .write_data (status.trig_count),
        .fifo_read  (fifo_read),
        .fifo_empty (fifo_empty),
        .fifo_data  (fifo_data),
        .lost_cnt   (status.lost_cnt)
    );

endmodule

/* rtl/trigger_fifo.sv */
`timescale 1ns/1ps
`include "tlu_macros.svh"

module trigger_fifo
(
    input  logic                BUS_CLK,
    input  logic                core_rst,
    input  logic                write,
    input  tlu_pkg::trig_word_t write_data,
    input  logic                fifo_read,
    output logic                fifo_empty,
    output tlu_pkg::trig_word_t fifo_data,
    output tlu_pkg::bus_byte_t  lost_cnt
);

    localparam int ADDR_W = $clog2(`FIFO_DEPTH);

    tlu_pkg::trig_word_t mem [`FIFO_DEPTH];
    logic [ADDR_W-1:0]   wr_ptr;
    logic [ADDR_W-1:0]   rd_ptr;
    logic [ADDR_W:0]     fill;
    logic                full;
    logic                do_write;
    logic                do_read;

    assign full       = (fill == `FIFO_DEPTH);
    assign fifo_empty = (fill == '0);
    assign do_write   = write && !full;   // no stall, word dropped when full
    assign do_read    = fifo_read && !fifo_empty;
    assign fifo_data  = mem[rd_ptr];      // head word, fall through

    always_ff @(posedge BUS_CLK)
    begin
        if (do_write)
            mem[wr_ptr] <= write_data;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            lost_cnt <= '0;
        end
        else
        begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_write, do_read})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: ;
            endcase
            if (write && full && (lost_cnt != 8'hff))
                lost_cnt <= lost_cnt + 8'd1;  // saturates
        end
    end

    a_no_read_empty: assert property (@(posedge BUS_CLK) disable iff (core_rst)
        fifo_read |-> !fifo_empty)
        else $error("fifo_read while FIFO empty");

endmodule

/* rtl/trigger_counter.sv */
`timescale 1ns/1ps

module trigger_counter
(
    input  logic                BUS_CLK,
    input  logic                core_rst,
    input  tlu_pkg::tlu_conf_t  conf,
    input  logic                counter_set,
    input  tlu_pkg::trig_word_t counter_set_value,
    input  logic                accept,
    output tlu_pkg::trig_word_t trig_count,
    output logic                limit_reached
);

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
            trig_count <= '0;
        else if (counter_set)   // bus preset beats a concurrent accept
            trig_count <= counter_set_value;
        else if (accept)
            trig_count <= trig_count + 32'd1;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
            limit_reached <= 1'b0;
        else
            limit_reached <= (conf.counter_max != '0) && (trig_count >= conf.counter_max);
    end

endmodule

/* rtl/handshake_timer.sv */
`timescale 1ns/1ps

module handshake_timer
(
    input  logic               BUS_CLK,
    input  logic               core_rst,
    input  tlu_pkg::tlu_conf_t conf,
    input  logic               timer_run,
    output logic               timeout,
    output tlu_pkg::bus_byte_t timeout_err_cnt
);

    tlu_pkg::bus_byte_t low_cnt;   // cycles spent waiting for trigger low

    assign timeout = timer_run && (low_cnt == conf.low_timeout);

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            low_cnt         <= '0;
            timeout_err_cnt <= '0;
        end
        else
        begin
            if (timer_run)
                low_cnt <= low_cnt + 8'd1;
            else
                low_cnt <= '0;   // restart for next handshake
            if (timeout && (timeout_err_cnt != 8'hff))
                timeout_err_cnt <= timeout_err_cnt + 8'd1;
        end
    end

endmodule

/* rtl/tlu_trigger_fsm.sv */
`timescale 1ns/1ps

module tlu_trigger_fsm
(
    input  logic               BUS_CLK,
    input  logic               core_rst,
    input  tlu_pkg::tlu_conf_t conf,
    input  logic               trigger_enable,
    input  logic               trigger_acknowledge,
    input  logic               trig_level,
    input  logic               trig_flag,
    input  logic               veto_active,
    input  logic               limit_reached,
    input  logic               timeout,
    output logic               accept,
    output logic               busy,
    output logic               timer_run
);

    tlu_pkg::fsm_state_t state;
    logic                enabled;
    logic                handshake;

    assign enabled   = (trigger_enable || conf.conf_enable) && !veto_active && !limit_reached;
    assign handshake = (conf.mode == tlu_pkg::MODE_TLU_HANDSHAKE);
    assign timer_run = (state == tlu_pkg::ST_WAIT_LOW);

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            state  <= tlu_pkg::ST_IDLE;
            accept <= 1'b0;
            busy   <= 1'b0;
        end
        else
        begin
            accept <= 1'b0;
            case (state)
                tlu_pkg::ST_IDLE:
                begin
                    if (trig_flag && enabled)
                    begin
                        accept <= 1'b1;
                        busy   <= handshake;  // TLU sees busy with the accept
                        state  <= handshake ? tlu_pkg::ST_WAIT_LOW : tlu_pkg::ST_WAIT_ACK;
                    end
                end
                tlu_pkg::ST_WAIT_LOW:
                begin
                    // timeout wins so FSM and error count agree
                    if (timeout)
                    begin
                        busy  <= 1'b0;
                        state <= tlu_pkg::ST_IDLE;
                    end
                    else if (!trig_level)
                        state <= tlu_pkg::ST_WAIT_ACK;
                end
                tlu_pkg::ST_WAIT_ACK:
                begin
                    if (trigger_acknowledge)
                    begin
                        busy  <= 1'b0;
                        state <= tlu_pkg::ST_IDLE;
                    end
                end
                default:
                    state <= tlu_pkg::ST_IDLE;
            endcase
        end
    end

    a_accept_from_idle: assert property (@(posedge BUS_CLK) disable iff (core_rst)
        accept |-> ($past(state) == tlu_pkg::ST_IDLE) && (state != tlu_pkg::ST_IDLE))
        else $error("accept without leaving idle");

    // busy belongs to the TLU handshake only
    a_no_busy_standard: assert property (@(posedge BUS_CLK) disable iff (core_rst)
        !handshake |-> !busy)
        else $error("busy raised in standard mode");

endmodule

/* rtl/trigger_input.sv */
`timescale 1ns/1ps

module trigger_input
(
    input  logic                BUS_CLK,
    input  logic                core_rst,
    input  tlu_pkg::tlu_conf_t  conf,
    input  tlu_pkg::trig_mask_t trigger,
    input  tlu_pkg::trig_mask_t trigger_veto,
    input  logic                tlu_trigger,
    output logic                trig_level,
    output logic                trig_flag,
    output logic                veto_active
);

    logic       trig_or;
    logic       veto_or;
    logic [2:0] sync_s1;   // {veto, tlu trigger, trigger or}
    logic [2:0] sync_s2;
    logic [2:0] sync_s3;
    logic       level_q;

    assign trig_or = |((trigger ^ conf.trig_invert) & conf.trig_select);
    assign veto_or = |(trigger_veto & conf.veto_select);

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            sync_s1 <= '0;
            sync_s2 <= '0;
            sync_s3 <= '0;
            level_q <= 1'b0;
        end
        else
        begin
            sync_s1 <= {veto_or, tlu_trigger, trig_or};
            sync_s2 <= sync_s1;
            sync_s3 <= sync_s2;
            level_q <= trig_level;
        end
    end

    assign trig_level  = (conf.mode == tlu_pkg::MODE_TLU_HANDSHAKE) ? sync_s3[1] : sync_s3[0];
    assign trig_flag   = trig_level && !level_q;  // rising edge
    assign veto_active = sync_s3[2];

endmodule

/* rtl/tlu_conf_regs.sv */
`timescale 1ns/1ps
`include "tlu_macros.svh"

module tlu_conf_regs
(
    input  logic                 BUS_CLK,
    input  logic                 RST,
    input  tlu_pkg::bus_addr_t   bus_add,
    input  tlu_pkg::bus_byte_t   bus_data_in,
    input  logic                 bus_rd,
    input  logic                 bus_wr,
    input  tlu_pkg::tlu_status_t status,
    output tlu_pkg::bus_byte_t   bus_data_out,
    output logic                 core_rst,
    output tlu_pkg::tlu_conf_t   conf,
    output logic                 counter_set,
    output tlu_pkg::trig_word_t  counter_set_value
);

    tlu_pkg::bus_byte_t  conf_byte;
    tlu_pkg::bus_byte_t  low_timeout;
    tlu_pkg::trig_mask_t trig_select;
    tlu_pkg::trig_mask_t veto_select;
    tlu_pkg::trig_mask_t trig_invert;
    tlu_pkg::trig_word_t counter_max;
    logic [23:0]         preset_low;   // bytes 8..10, used when 11 is written
    tlu_pkg::trig_word_t count_buf;
    logic                soft_rst;

    assign soft_rst = bus_wr && (bus_add == `ADDR_SOFT_RST_VERSION);

    always_ff @(posedge BUS_CLK)
    begin
        core_rst <= RST || soft_rst;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (core_rst)
        begin
            conf_byte   <= '0;
            low_timeout <= `DEF_LOW_TIMEOUT;
            trig_select <= '0;
            veto_select <= `DEF_VETO_SELECT;
            trig_invert <= '0;
            counter_max <= '0;
            preset_low  <= '0;
        end
        else if (bus_wr)
        begin
            case (bus_add)
                `ADDR_CONF:        conf_byte          <= bus_data_in;
                `ADDR_LOW_TIMEOUT: low_timeout        <= bus_data_in;
                `ADDR_COUNTER0:    preset_low[7:0]    <= bus_data_in;
                `ADDR_COUNTER1:    preset_low[15:8]   <= bus_data_in;
                `ADDR_COUNTER2:    preset_low[23:16]  <= bus_data_in;
                `ADDR_TRIG_SELECT: trig_select        <= bus_data_in;
                `ADDR_VETO_SELECT: veto_select        <= bus_data_in;
                `ADDR_TRIG_INVERT: trig_invert        <= bus_data_in;
                `ADDR_MAX0:        counter_max[7:0]   <= bus_data_in;
                `ADDR_MAX1:        counter_max[15:8]  <= bus_data_in;
                `ADDR_MAX2:        counter_max[23:16] <= bus_data_in;
                `ADDR_MAX3:        counter_max[31:24] <= bus_data_in;
                default: ;
            endcase
        end
    end

    // top byte comes straight from the bus
    assign counter_set       = bus_wr && (bus_add == `ADDR_COUNTER3);
    assign counter_set_value = {bus_data_in, preset_low};

    always_comb
    begin
        conf.mode        = tlu_pkg::trig_mode_t'(conf_byte[0]);
        conf.conf_enable = conf_byte[3];
        conf.trig_select = trig_select;
        conf.veto_select = veto_select;
        conf.trig_invert = trig_invert;
        conf.counter_max = counter_max;
        conf.low_timeout = low_timeout;
    end

    // keeps the upper bytes consistent with the low byte just read
    always_ff @(posedge BUS_CLK)
    begin
        if (bus_rd && (bus_add == `ADDR_COUNTER0))
            count_buf <= status.trig_count;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            bus_data_out <= '0;
        else if (bus_rd)
        begin
            case (bus_add)
                `ADDR_SOFT_RST_VERSION: bus_data_out <= `TLU_VERSION;
                `ADDR_CONF:             bus_data_out <= conf_byte;
                `ADDR_LOW_TIMEOUT:      bus_data_out <= low_timeout;
                `ADDR_COUNTER0:         bus_data_out <= status.trig_count[7:0]; // live
                `ADDR_COUNTER1:         bus_data_out <= count_buf[15:8];
                `ADDR_COUNTER2:         bus_data_out <= count_buf[23:16];
                `ADDR_COUNTER3:         bus_data_out <= count_buf[31:24];
                `ADDR_LOST_CNT:         bus_data_out <= status.lost_cnt;
                `ADDR_TRIG_SELECT:      bus_data_out <= trig_select;
                `ADDR_VETO_SELECT:      bus_data_out <= veto_select;
                `ADDR_TRIG_INVERT:      bus_data_out <= trig_invert;
                `ADDR_MAX0:             bus_data_out <= counter_max[7:0];
                `ADDR_MAX1:             bus_data_out <= counter_max[15:8];
                `ADDR_MAX2:             bus_data_out <= counter_max[23:16];
                `ADDR_MAX3:             bus_data_out <= counter_max[31:24];
                `ADDR_TIMEOUT_ERR:      bus_data_out <= status.timeout_err_cnt;
                default:                bus_data_out <= '0;
            endcase
        end
    end

    // core_rst at most one cycle past RST or a single soft reset strobe
    a_core_rst_len: assert property (@(posedge BUS_CLK)
        !RST && !$past(RST) && $past(core_rst) |-> !core_rst)
        else $error("core_rst held beyond RST");

endmodule

/* rtl/tlu_pkg.sv */
package tlu_pkg;

    typedef logic [15:0] bus_addr_t;
    typedef logic [7:0]  bus_byte_t;
    typedef logic [31:0] trig_word_t;  // trigger number, also the FIFO word
    typedef logic [7:0]  trig_mask_t;  // one bit per input line

    typedef enum logic {
        MODE_STANDARD,
        MODE_TLU_HANDSHAKE
    } trig_mode_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_LOW,
        ST_WAIT_ACK
    } fsm_state_t;

    typedef struct packed {
        trig_mode_t mode;
        logic       conf_enable;
        trig_mask_t trig_select;
        trig_mask_t veto_select;
        trig_mask_t trig_invert;
        trig_word_t counter_max;   // 0 disables the limit
        bus_byte_t  low_timeout;
    } tlu_conf_t;

    typedef struct packed {
        trig_word_t trig_count;
        bus_byte_t  lost_cnt;
        bus_byte_t  timeout_err_cnt;
    } tlu_status_t;

endpackage

/* rtl/tlu_macros.svh */
`ifndef TLU_MACROS_SVH
`define TLU_MACROS_SVH

`define TLU_VERSION            8'd6

// register map, byte wide
`define ADDR_SOFT_RST_VERSION  16'd0   // write resets, read gives version
`define ADDR_CONF              16'd1   // bit 0 mode, bit 3 enable
`define ADDR_LOW_TIMEOUT       16'd3
`define ADDR_COUNTER0          16'd8   // read latches all four bytes
`define ADDR_COUNTER1          16'd9
`define ADDR_COUNTER2          16'd10
`define ADDR_COUNTER3          16'd11  // write loads the counter
`define ADDR_LOST_CNT          16'd12
`define ADDR_TRIG_SELECT       16'd13
`define ADDR_VETO_SELECT       16'd14
`define ADDR_TRIG_INVERT       16'd15
`define ADDR_MAX0              16'd16
`define ADDR_MAX1              16'd17
`define ADDR_MAX2              16'd18
`define ADDR_MAX3              16'd19
`define ADDR_TIMEOUT_ERR       16'd22

`define DEF_LOW_TIMEOUT        8'hff
`define DEF_VETO_SELECT        8'hff   // all veto lines active

`define FIFO_DEPTH             8

`endif
